// File: tb.f
source/trace_pkg.sv
source/commit_classifier.sv
source/trace_fifo.sv
source/rr_arbiter.sv
source/trace_handshake.sv
source/retire_counters.sv
source/trace_top.sv
testbench/tb_clk_gen.sv
testbench/tb_trace_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
verilator --binary --timing --assert -Wno-fatal --top-module tb_trace_top -f tb.f \
  -o sim_trace > build.log 2>&1 \
  && ./obj_dir/sim_trace > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && exit 1 || exit 0

// File: testbench/tb_trace_top.sv
`default_nettype none

module tb_trace_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NrPorts    = 2;
  localparam int unsigned QueueDepth = 8;
  localparam int unsigned Seed       = 32'hbf77b5a4;
  localparam int unsigned DrainLimit = 5000;
  localparam int unsigned QuietLen   = 10;
  localparam int          FairLen    = 2 * int'(QueueDepth);

  logic                                   clk;
  logic                                   rst_n;
  trace_pkg::commit_entry_t [NrPorts-1:0] commit;
  logic [NrPorts-1:0]                     commit_ack;
  trace_pkg::priv_lvl_e                   priv_lvl;
  logic                                   debug_mode;
  logic                                   trace_req;
  logic                                   trace_ack;
  trace_pkg::trace_out_t                  trace_word;
  logic [trace_pkg::CNT_W-1:0]            cnt_instr;
  logic [trace_pkg::CNT_W-1:0]            cnt_exc;
  logic [trace_pkg::CNT_W-1:0]            cnt_irq;
  logic [trace_pkg::CNT_W-1:0]            cnt_drop;

  // reference model, one record queue per port
  trace_pkg::trace_rec_t model_q [NrPorts][$];
  int unsigned exp_instr;
  int unsigned exp_exc;
  int unsigned exp_irq;
  int unsigned commit_count;
  int unsigned rx_count;
  int unsigned value_errors;
  int unsigned timeout_errors;
  bit          aborted;

  // ack responder state
  bit                          hold_ack;
  bit                          subseq_mode;
  int unsigned                 ack_max_delay;
  int unsigned                 ack_delay;
  int                          fair_idx;
  logic                        prev_req;
  trace_pkg::trace_out_t       prev_word;
  logic [trace_pkg::PORT_W-1:0] last_port;

  tb_clk_gen #(
    .PeriodNs ( 100 )
  ) i_clk_gen (
    .clk_o ( clk )
  );

  trace_top #(
    .NrCommitPorts ( NrPorts    ),
    .QueueDepth    ( QueueDepth )
  ) i_dut (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .commit_i     ( commit     ),
    .commit_ack_i ( commit_ack ),
    .priv_lvl_i   ( priv_lvl   ),
    .debug_mode_i ( debug_mode ),
    .trace_req_o  ( trace_req  ),
    .trace_ack_i  ( trace_ack  ),
    .trace_o      ( trace_word ),
    .cnt_instr_o  ( cnt_instr  ),
    .cnt_exc_o    ( cnt_exc    ),
    .cnt_irq_o    ( cnt_irq    ),
    .cnt_drop_o   ( cnt_drop   )
  );

  task automatic report_error(input string msg);
    value_errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // ---------------------------------------------------------------------------
  // model of the classification rules
  // ---------------------------------------------------------------------------
  function automatic trace_pkg::trace_rec_t expected_record(
    input trace_pkg::commit_entry_t c,
    input logic [1:0]               priv,
    input logic                     dbg
  );
    trace_pkg::trace_rec_t r;
    r.pc    = c.pc;
    r.cause = c.cause;
    r.tval  = c.tval;
    if (!c.ex_valid) begin
      r.kind = trace_pkg::kind_instr;
    end else if (c.cause[trace_pkg::XLEN-1]) begin
      r.kind = trace_pkg::kind_interrupt;
    end else begin
      r.kind = trace_pkg::kind_exception;
    end
    if (dbg) begin
      r.mode = trace_pkg::mode_d;
    end else if (priv == 2'd3) begin
      r.mode = trace_pkg::mode_m;
    end else if (priv == 2'd1) begin
      r.mode = trace_pkg::mode_s;
    end else begin
      r.mode = trace_pkg::mode_u;
    end
    return r;
  endfunction

  function automatic void count_kind(input trace_pkg::trace_kind_e kind);
    case (kind)
      trace_pkg::kind_instr:     exp_instr++;
      trace_pkg::kind_exception: exp_exc++;
      default:                   exp_irq++;
    endcase
  endfunction

  // compare one delivered word against the model of its port
  task automatic check_received(input trace_pkg::trace_out_t w);
    trace_pkg::trace_rec_t exp_rec;
    int                    p;
    p = int'(w.port);
    // lost records are skipped when overflow is allowed
    if (subseq_mode) begin
      while (model_q[p].size() > 0 && model_q[p][0] != w.rec) begin
        void'(model_q[p].pop_front());
      end
    end
    assert (model_q[p].size() > 0)
      else report_error($sformatf("port %0d sent a record that was never committed", p));
    if (model_q[p].size() > 0) begin
      exp_rec = model_q[p].pop_front();
      assert (w.rec == exp_rec)
        else report_error($sformatf("port %0d got kind %0d mode %0d pc %h, expected %0d %0d %h",
                                    p, w.rec.kind, w.rec.mode, w.rec.pc,
                                    exp_rec.kind, exp_rec.mode, exp_rec.pc));
    end
    if (fair_idx >= 0) begin
      if (fair_idx > 0 && fair_idx < FairLen) begin
        assert (w.port != last_port)
          else report_error($sformatf("port %0d served twice in a row", p));
      end
      fair_idx++;
    end
    last_port = w.port;
    rx_count++;
  endtask

  // handshake checks first, then the ack response for this cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (trace_req && prev_req) begin
        assert (trace_word == prev_word)
          else report_error("trace_o changed while trace_req_o was high");
      end
      if (trace_req && !prev_req) begin
        assert (!trace_ack)
          else report_error("trace_req_o rose while trace_ack_i was high");
      end
      if (ack_delay > 0) begin
        ack_delay--;
      end else if (trace_req && !trace_ack && !hold_ack) begin
        check_received(trace_word);
        trace_ack = 1'b1;
        ack_delay = $urandom_range(0, ack_max_delay);
      end else if (!trace_req && trace_ack) begin
        trace_ack = 1'b0;
        ack_delay = $urandom_range(0, ack_max_delay);
      end
      prev_req  = trace_req;
      prev_word = trace_word;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  task automatic drive_commits(input int unsigned cycles, input int unsigned rate_pct);
    trace_pkg::trace_rec_t rec;
    logic [63:0]           pc_bits;
    if (aborted) return;
    for (int unsigned c = 0; c < cycles; c++) begin
      @(negedge clk);
      debug_mode = ($urandom_range(0, 3) == 0);
      priv_lvl   = trace_pkg::priv_lvl_e'(2'($urandom_range(0, 3)));
      for (int p = 0; p < int'(NrPorts); p++) begin
        pc_bits            = {$urandom, $urandom};
        commit[p].pc       = pc_bits[trace_pkg::VLEN-1:0];
        commit[p].ex_valid = ($urandom_range(0, 2) == 0);
        commit[p].cause    = {$urandom, $urandom};
        commit[p].tval     = $urandom;
        commit_ack[p]      = ($urandom_range(0, 99) < rate_pct);
        if (commit_ack[p]) begin
          rec = expected_record(commit[p], priv_lvl, debug_mode);
          model_q[p].push_back(rec);
          count_kind(rec.kind);
          commit_count++;
        end
      end
    end
    @(negedge clk);
    commit_ack = '0;
  endtask

  // stream idle for a while once the commits have stopped
  task automatic wait_quiet(input string what);
    int unsigned cycles;
    int unsigned quiet;
    if (aborted) return;
    cycles = 0;
    quiet  = 0;
    while (quiet < QuietLen && cycles < DrainLimit) begin
      @(negedge clk);
      #1;
      cycles++;
      if (!trace_req && !trace_ack) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < QuietLen) begin
      $display("timeout: trace stream still busy after %0d cycles in %s", cycles, what);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_counts(input bit expect_no_drops);
    if (aborted) return;
    assert (cnt_instr == exp_instr)
      else report_error($sformatf("cnt_instr_o %0d, expected %0d", cnt_instr, exp_instr));
    assert (cnt_exc == exp_exc)
      else report_error($sformatf("cnt_exc_o %0d, expected %0d", cnt_exc, exp_exc));
    assert (cnt_irq == exp_irq)
      else report_error($sformatf("cnt_irq_o %0d, expected %0d", cnt_irq, exp_irq));
    assert (rx_count + cnt_drop == commit_count)
      else report_error($sformatf("%0d received + %0d dropped, %0d committed",
                                  rx_count, cnt_drop, commit_count));
    if (expect_no_drops) begin
      assert (cnt_drop == 0)
        else report_error($sformatf("cnt_drop_o %0d without back-pressure", cnt_drop));
      for (int p = 0; p < int'(NrPorts); p++) begin
        assert (model_q[p].size() == 0)
          else report_error($sformatf("port %0d still owes %0d records", p, model_q[p].size()));
      end
    end
  endtask

  initial begin
    void'($urandom(Seed));
    rst_n         = 1'b0;
    commit        = '0;
    commit_ack    = '0;
    priv_lvl      = trace_pkg::priv_m;
    debug_mode    = 1'b0;
    trace_ack     = 1'b0;
    hold_ack      = 1'b0;
    subseq_mode   = 1'b0;
    ack_max_delay = 1;
    ack_delay     = 0;
    fair_idx      = -1;
    prev_req      = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    repeat (10) begin
      @(negedge clk);
      assert (!trace_req)
        else report_error("trace_req_o high with no commits");
      assert (cnt_instr == 0 && cnt_exc == 0 && cnt_irq == 0 && cnt_drop == 0)
        else report_error("counters not zero after reset");
    end

    // low rate with a fast ack, then slower acks
    drive_commits(400, 5);
    wait_quiet("low-rate traffic");
    check_counts(1'b1);
    ack_max_delay = 3;
    drive_commits(600, 4);
    wait_quiet("classification traffic");
    check_counts(1'b1);

    // --------------------------------------------------------------------------
    // back-pressure, then drain with the fairness check
    // --------------------------------------------------------------------------
    hold_ack      = 1'b1;
    subseq_mode   = 1'b1;
    ack_max_delay = 1;
    drive_commits(40, 100);
    repeat (4) @(negedge clk);
    #1;
    fair_idx = 0;
    hold_ack = 1'b0;
    wait_quiet("back-pressure drain");
    if (!aborted) begin
      assert (cnt_drop != 0)
        else report_error("no drops counted under back-pressure");
      assert (fair_idx >= FairLen)
        else report_error($sformatf("only %0d records after the stall", fair_idx));
    end
    fair_idx = -1;
    for (int p = 0; p < int'(NrPorts); p++) begin
      model_q[p].delete();
    end
    check_counts(1'b0);

    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 100
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // free-running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: source/trace_top.sv
`default_nettype none

module trace_top #(
  parameter int unsigned NrCommitPorts = trace_pkg::NR_COMMIT_PORTS_DEFAULT,
  parameter int unsigned QueueDepth    = trace_pkg::QUEUE_DEPTH_DEFAULT
) (
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  input  wire trace_pkg::commit_entry_t [NrCommitPorts-1:0] commit_i,
  input  wire logic [NrCommitPorts-1:0]                     commit_ack_i,
  input  wire trace_pkg::priv_lvl_e                         priv_lvl_i,
  input  wire logic                                         debug_mode_i,
  output logic                                              trace_req_o,
  input  wire logic                                         trace_ack_i,
  output trace_pkg::trace_out_t                             trace_o,
  output logic [trace_pkg::CNT_W-1:0]                       cnt_instr_o,
  output logic [trace_pkg::CNT_W-1:0]                       cnt_exc_o,
  output logic [trace_pkg::CNT_W-1:0]                       cnt_irq_o,
  output logic [trace_pkg::CNT_W-1:0]                       cnt_drop_o
);

  // classifier to queues and counters
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_cls;
  logic [NrCommitPorts-1:0]                  rec_valid;
  // queues to arbiter
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_head;
  logic [NrCommitPorts-1:0]                  q_empty;
  logic [NrCommitPorts-1:0]                  q_pop;
  logic [NrCommitPorts-1:0]                  q_drop;
  // arbiter to output stage
  trace_pkg::trace_out_t                     arb_out;
  logic                                      arb_load;
  logic                                      hs_idle;

  commit_classifier #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_classifier (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .commit_ack_i ( commit_ack_i ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .debug_mode_i ( debug_mode_i ),
    .rec_o        ( rec_cls      ),
    .rec_valid_o  ( rec_valid    )
  );

  // --------------------------------------------------------------------------
  // one queue per commit port
  // --------------------------------------------------------------------------
  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_queue
    trace_fifo #(
      .QueueDepth ( QueueDepth )
    ) i_fifo (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .push_i  ( rec_valid[p] ),
      .rec_i   ( rec_cls[p]   ),
      .pop_i   ( q_pop[p]     ),
      .rec_o   ( rec_head[p]  ),
      .empty_o ( q_empty[p]   ),
      .drop_o  ( q_drop[p]    )
    );
  end

  rr_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_arbiter (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .empty_i ( q_empty  ),
    .rec_i   ( rec_head ),
    .idle_i  ( hs_idle  ),
    .pop_o   ( q_pop    ),
    .out_o   ( arb_out  ),
    .load_o  ( arb_load )
  );

  trace_handshake i_handshake (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .load_i      ( arb_load    ),
    .out_i       ( arb_out     ),
    .idle_o      ( hs_idle     ),
    .trace_req_o ( trace_req_o ),
    .trace_ack_i ( trace_ack_i ),
    .trace_o     ( trace_o     )
  );

  retire_counters #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_counters (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rec_valid_i ( rec_valid   ),
    .rec_i       ( rec_cls     ),
    .drop_i      ( q_drop      ),
    .cnt_instr_o ( cnt_instr_o ),
    .cnt_exc_o   ( cnt_exc_o   ),
    .cnt_irq_o   ( cnt_irq_o   ),
    .cnt_drop_o  ( cnt_drop_o  )
  );

endmodule

`default_nettype wire

// File: source/retire_counters.sv
`default_nettype none

module retire_counters #(
  parameter int unsigned NrCommitPorts = trace_pkg::NR_COMMIT_PORTS_DEFAULT
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  input  wire logic [NrCommitPorts-1:0]                  rec_valid_i,
  input  wire trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_i,
  input  wire logic [NrCommitPorts-1:0]                  drop_i,
  output logic [trace_pkg::CNT_W-1:0]                    cnt_instr_o,
  output logic [trace_pkg::CNT_W-1:0]                    cnt_exc_o,
  output logic [trace_pkg::CNT_W-1:0]                    cnt_irq_o,
  output logic [trace_pkg::CNT_W-1:0]                    cnt_drop_o
);

  logic [trace_pkg::CNT_W-1:0] add_instr;
  logic [trace_pkg::CNT_W-1:0] add_exc;
  logic [trace_pkg::CNT_W-1:0] add_irq;
  logic [trace_pkg::CNT_W-1:0] add_drop;

  // events of all ports in this cycle
  always_comb begin
    add_instr = '0;
    add_exc   = '0;
    add_irq   = '0;
    add_drop  = '0;
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (rec_valid_i[p]) begin
        case (rec_i[p].kind)
          trace_pkg::kind_instr:     add_instr = add_instr + 1'b1;
          trace_pkg::kind_exception: add_exc   = add_exc + 1'b1;
          trace_pkg::kind_interrupt: add_irq   = add_irq + 1'b1;
          default:                   ;
        endcase
      end
      if (drop_i[p]) begin
        add_drop = add_drop + 1'b1;
      end
    end
  end

  // free-running, wrap on overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_instr_o <= '0;
      cnt_exc_o   <= '0;
      cnt_irq_o   <= '0;
      cnt_drop_o  <= '0;
    end else begin
      cnt_instr_o <= cnt_instr_o + add_instr;
      cnt_exc_o   <= cnt_exc_o + add_exc;
      cnt_irq_o   <= cnt_irq_o + add_irq;
      cnt_drop_o  <= cnt_drop_o + add_drop;
    end
  end

endmodule

`default_nettype wire

// File: source/trace_handshake.sv
`default_nettype none

module trace_handshake (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  load_i,
  input  wire trace_pkg::trace_out_t out_i,
  output logic                       idle_o,
  output logic                       trace_req_o,
  input  wire logic                  trace_ack_i,
  output trace_pkg::trace_out_t      trace_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_ack_low
  } hs_state_e;

  hs_state_e             state_q;
  hs_state_e             state_d;
  trace_pkg::trace_out_t word_q;

  // --------------------------------------------------------------------------
  // four-phase FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:    if (load_i)       state_d = st_req;
      st_req:     if (trace_ack_i)  state_d = st_ack_low;
      // wait for the consumer to release ack before the next word
      st_ack_low: if (!trace_ack_i) state_d = st_idle;
      default:                      state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // word held stable from load until the next load
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && load_i) begin
      word_q <= out_i;
    end
  end

  assign idle_o      = (state_q == st_idle);
  assign trace_req_o = (state_q == st_req);
  assign trace_o     = word_q;

endmodule

`default_nettype wire

// File: source/rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NrCommitPorts = trace_pkg::NR_COMMIT_PORTS_DEFAULT
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_ni,
  input  wire logic [NrCommitPorts-1:0]                  empty_i,
  input  wire trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_i,
  input  wire logic                                      idle_i,
  output logic [NrCommitPorts-1:0]                       pop_o,
  output trace_pkg::trace_out_t                          out_o,
  output logic                                           load_o
);

  localparam int unsigned IdxW = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] sel;
  logic            found;

  // first non-empty queue at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = ptr_q;
    for (int k = 0; k < NrCommitPorts; k++) begin
      idx = (int'(ptr_q) + k) % NrCommitPorts;
      if (!found && !empty_i[idx]) begin
        found = 1'b1;
        sel   = IdxW'(idx);
      end
    end
  end

  assign load_o    = idle_i & found;
  assign out_o.rec = rec_i[sel];
  assign out_o.port = trace_pkg::PORT_W'(sel);

  always_comb begin
    pop_o = '0;
    pop_o[sel] = load_o;
  end

  // winner gets lowest priority next time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (load_o) begin
      ptr_q <= (sel == IdxW'(NrCommitPorts - 1)) ? '0 : sel + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/trace_fifo.sv
`default_nettype none

module trace_fifo #(
  parameter int unsigned QueueDepth = trace_pkg::QUEUE_DEPTH_DEFAULT
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  push_i,
  input  wire trace_pkg::trace_rec_t rec_i,
  input  wire logic                  pop_i,
  output trace_pkg::trace_rec_t      rec_o,
  output logic                       empty_o,
  output logic                       drop_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  trace_pkg::trace_rec_t mem [QueueDepth];
  logic [PtrW-1:0]       wr_ptr_q;
  logic [PtrW-1:0]       rd_ptr_q;
  logic [CntW-1:0]       count_q;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count_q == CntW'(QueueDepth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  // record arriving at a full queue is lost
  assign drop_o = push_i & full;

  assign rec_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= rec_i;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/commit_classifier.sv
`default_nettype none

module commit_classifier #(
  parameter int unsigned NrCommitPorts = trace_pkg::NR_COMMIT_PORTS_DEFAULT
) (
  input  wire logic                                         clk_i,
  input  wire logic                                         rst_ni,
  input  wire trace_pkg::commit_entry_t [NrCommitPorts-1:0] commit_i,
  input  wire logic [NrCommitPorts-1:0]                     commit_ack_i,
  input  wire trace_pkg::priv_lvl_e                         priv_lvl_i,
  input  wire logic                                         debug_mode_i,
  output trace_pkg::trace_rec_t [NrCommitPorts-1:0]         rec_o,
  output logic [NrCommitPorts-1:0]                          rec_valid_o
);

  trace_pkg::trace_mode_e                   mode;
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_d;
  trace_pkg::trace_rec_t [NrCommitPorts-1:0] rec_q;
  logic [NrCommitPorts-1:0]                  valid_q;

  // one mode for all ports, debug wins over the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = trace_pkg::mode_d;
    end else begin
      case (priv_lvl_i)
        trace_pkg::priv_m: mode = trace_pkg::mode_m;
        trace_pkg::priv_s: mode = trace_pkg::mode_s;
        default:           mode = trace_pkg::mode_u;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // per-port classification
  // --------------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < NrCommitPorts; p++) begin
      rec_d[p].mode  = mode;
      rec_d[p].pc    = commit_i[p].pc;
      rec_d[p].cause = commit_i[p].cause;
      rec_d[p].tval  = commit_i[p].tval;
      if (!commit_i[p].ex_valid) begin
        rec_d[p].kind = trace_pkg::kind_instr;
      end else if (commit_i[p].cause[trace_pkg::XLEN-1]) begin
        // msb of cause marks an asynchronous trap
        rec_d[p].kind = trace_pkg::kind_interrupt;
      end else begin
        rec_d[p].kind = trace_pkg::kind_exception;
      end
    end
  end

  // payload follows the ack
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (commit_ack_i[p]) begin
        rec_q[p] <= rec_d[p];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= commit_ack_i;
    end
  end

  assign rec_o       = rec_q;
  assign rec_valid_o = valid_q;

endmodule

`default_nettype wire

// File: source/trace_pkg.sv
`default_nettype none

package trace_pkg;

  // --------------------------------------------------------------------------
  // widths and defaults
  // --------------------------------------------------------------------------
  localparam int unsigned VLEN   = 39;
  localparam int unsigned XLEN   = 64;
  localparam int unsigned INSN_W = 32;
  localparam int unsigned CNT_W  = 32;

  localparam int unsigned NR_COMMIT_PORTS_DEFAULT = 2;
  localparam int unsigned QUEUE_DEPTH_DEFAULT     = 8;

  // port index in the output word, never narrower than one bit
  localparam int unsigned PORT_W =
    (NR_COMMIT_PORTS_DEFAULT > 1) ? $clog2(NR_COMMIT_PORTS_DEFAULT) : 1;

  // --------------------------------------------------------------------------
  // encodings
  // --------------------------------------------------------------------------
  // privilege level as the CSR file reports it
  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_s = 2'd1,
    priv_m = 2'd3
  } priv_lvl_e;

  typedef enum logic [1:0] {
    mode_u = 2'd0,
    mode_s = 2'd1,
    mode_m = 2'd2,
    mode_d = 2'd3
  } trace_mode_e;

  typedef enum logic [1:0] {
    kind_instr     = 2'd0,
    kind_exception = 2'd1,
    kind_interrupt = 2'd2
  } trace_kind_e;

  // --------------------------------------------------------------------------
  // records
  // --------------------------------------------------------------------------
  // one commit port as seen at the commit stage
  typedef struct packed {
    logic [VLEN-1:0]   pc;
    logic              ex_valid;
    logic [XLEN-1:0]   cause;
    logic [INSN_W-1:0] tval;
  } commit_entry_t;

  typedef struct packed {
    trace_kind_e       kind;
    trace_mode_e       mode;
    logic [VLEN-1:0]   pc;
    logic [XLEN-1:0]   cause;
    logic [INSN_W-1:0] tval;
  } trace_rec_t;

  // record on the output stream, tagged with its source port
  typedef struct packed {
    logic [PORT_W-1:0] port;
    trace_rec_t        rec;
  } trace_out_t;

endpackage

`default_nettype wire
